/* logic/drp_bridge.sv */
`timescale 1ns/1ns
`include "turf_defines.svh"

module drp_bridge (
    input  logic                                       wb_clk_i,
    input  logic                                       reset_i,
    input  gt_ctrl_pkg::bus_req_t                      win_req_i,
    output gt_ctrl_pkg::bus_rsp_t                      win_rsp_o,
    output logic [`TURF_NUM_LANES-1:0]                 drp_en_o,
    output logic                                       drp_we_o,
    output logic [`TURF_DRP_ADR_W-1:0]                 drp_addr_o,
    output logic [`TURF_DRP_DAT_W-1:0]                 drp_di_o,
    input  logic [`TURF_NUM_LANES-1:0]                 drp_rdy_i,
    input  logic [`TURF_NUM_LANES*`TURF_DRP_DAT_W-1:0] drp_do_i
);

    gt_ctrl_pkg::drp_state_t     state;
    logic                        lane_q;
    logic                        ack_q;
    logic [`TURF_DRP_DAT_W-1:0]  rdata_q;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state    <= gt_ctrl_pkg::DRP_IDLE;
            drp_en_o <= '0;
            ack_q    <= 1'b0;
        end else begin
            // enable and ack are both single-cycle pulses
            drp_en_o <= '0;
            ack_q    <= 1'b0;
            case (state)
                gt_ctrl_pkg::DRP_IDLE: begin
                    if (win_req_i.cyc && win_req_i.stb) begin
                        drp_en_o[win_req_i.adr[`TURF_LANE_BIT]] <= 1'b1;
                        state <= gt_ctrl_pkg::DRP_WAIT;
                    end
                end
                gt_ctrl_pkg::DRP_WAIT: begin
                    // only the lane we started on can finish the access
                    if (drp_rdy_i[lane_q]) begin
                        ack_q <= 1'b1;
                        state <= gt_ctrl_pkg::DRP_DONE;
                    end
                end
                gt_ctrl_pkg::DRP_DONE: begin
                    // hold off until the master ends this cycle
                    if (!win_req_i.cyc) begin
                        state <= gt_ctrl_pkg::DRP_IDLE;
                    end
                end
                default: begin
                    state <= gt_ctrl_pkg::DRP_IDLE;
                end
            endcase
        end
    end

    // transaction payload, captured with the enable
    always_ff @(posedge wb_clk_i) begin
        if (state == gt_ctrl_pkg::DRP_IDLE && win_req_i.cyc && win_req_i.stb) begin
            lane_q     <= win_req_i.adr[`TURF_LANE_BIT];
            drp_we_o   <= win_req_i.we;
            drp_addr_o <= win_req_i.adr[`TURF_DRP_ADR_W-1:0];
            drp_di_o   <= win_req_i.dat[`TURF_DRP_DAT_W-1:0];
        end
        if (state == gt_ctrl_pkg::DRP_WAIT && drp_rdy_i[lane_q]) begin
            rdata_q <= drp_do_i[lane_q*`TURF_DRP_DAT_W +: `TURF_DRP_DAT_W];
        end
    end

    assign win_rsp_o.ack = ack_q;
    assign win_rsp_o.dat = {{(`TURF_DAT_W-`TURF_DRP_DAT_W){1'b0}}, rdata_q};

    en_onehot: assert property (
        @(posedge wb_clk_i) disable iff (reset_i)
        $onehot0(drp_en_o)
    ) else $error("DRP enable on more than one lane");

    // a lane never sees a second enable while it is still busy
    en_single_pulse: assert property (
        @(posedge wb_clk_i) disable iff (reset_i)
        (drp_en_o != '0) |=> (drp_en_o == '0)
    ) else $error("DRP enable held longer than one cycle");

endmodule

/* logic/gt_ctrl_pkg.sv */
`include "turf_defines.svh"

package gt_ctrl_pkg;

    // one bus cycle as seen by the target
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [3:0]             sel;
        logic [`TURF_ADR_W-1:0] adr;
        logic [`TURF_DAT_W-1:0] dat;
    } bus_req_t;

    typedef struct packed {
        logic                   ack;
        logic [`TURF_DAT_W-1:0] dat;
    } bus_rsp_t;

    // status bits, read back zero-extended in the low bits
    typedef struct packed {
        logic [`TURF_NUM_LANES-1:0] rx_block_lock;
        logic                       qpll_lock;
        logic                       powergood;
    } gt_status_t;

    typedef enum logic [1:0] {
        DRP_IDLE,
        DRP_WAIT,
        DRP_DONE
    } drp_state_t;

endpackage

/* logic/gt_ctrl_regs.sv */
`timescale 1ns/1ns
`include "turf_defines.svh"

module gt_ctrl_regs (
    input  logic                    wb_clk_i,
    input  logic                    reset_i,
    input  gt_ctrl_pkg::bus_req_t   bus_req_i,
    input  gt_ctrl_pkg::bus_rsp_t   drp_rsp_i,
    input  gt_ctrl_pkg::gt_status_t status_i,
    output gt_ctrl_pkg::bus_rsp_t   bus_rsp_o,
    output logic                    gt_rst_o
);

    localparam int STATUS_W = $bits(gt_ctrl_pkg::gt_status_t);

    logic                    in_window;
    logic                    local_sel;
    logic                    local_ack;
    logic                    xcvr_rst;
    gt_ctrl_pkg::gt_status_t status_q;

    // the single window test: keeps the register out of DRP space
    // and picks the response source below
    assign in_window = bus_req_i.adr[`TURF_DRP_WINDOW_BIT];
    assign local_sel = bus_req_i.cyc && bus_req_i.stb && !in_window;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            local_ack <= 1'b0;
            xcvr_rst  <= 1'b0;
        end else begin
            // one ack per access, master drops cyc once it sees it
            local_ack <= local_sel && !local_ack;
            if (local_sel && !local_ack && bus_req_i.we && bus_req_i.sel[0]) begin
                xcvr_rst <= bus_req_i.dat[0];
            end
        end
    end

    // status is free-running, a read sees the inputs of the previous cycle
    always_ff @(posedge wb_clk_i) begin
        status_q <= status_i;
    end

    always_comb begin
        if (in_window) begin
            bus_rsp_o = drp_rsp_i;
        end else begin
            bus_rsp_o.ack = local_ack && bus_req_i.cyc;
            bus_rsp_o.dat = {{(`TURF_DAT_W-STATUS_W){1'b0}}, status_q};
        end
    end

    assign gt_rst_o = xcvr_rst;

    // covers the bridge side too, whose ack is registered on the DRP ready
    ack_needs_cyc: assert property (
        @(posedge wb_clk_i) disable iff (reset_i)
        bus_rsp_o.ack |-> bus_req_i.cyc
    ) else $error("bus ack seen without cyc");

endmodule

/* logic/turf_ctrl_top.sv */
`timescale 1ns/1ns
`include "turf_defines.svh"

module turf_ctrl_top (
    input  logic                                       wb_clk_i,
    input  logic                                       reset_i,
    input  gt_ctrl_pkg::bus_req_t                      bus_req_i,
    output gt_ctrl_pkg::bus_rsp_t                      bus_rsp_o,
    input  gt_ctrl_pkg::gt_status_t                    status_i,
    output logic                                       gt_rst_o,
    output logic [`TURF_NUM_LANES-1:0]                 drp_en_o,
    output logic                                       drp_we_o,
    output logic [`TURF_DRP_ADR_W-1:0]                 drp_addr_o,
    output logic [`TURF_DRP_DAT_W-1:0]                 drp_di_o,
    input  logic [`TURF_NUM_LANES-1:0]                 drp_rdy_i,
    input  logic [`TURF_NUM_LANES*`TURF_DRP_DAT_W-1:0] drp_do_i,
    input  logic                                       hdr_valid_i,
    input  logic [15:0]                                hdr_dest_i,
    output logic                                       route_valid_o,
    output udp_route_pkg::route_t                      route_o
);

    gt_ctrl_pkg::bus_req_t win_req;
    gt_ctrl_pkg::bus_rsp_t win_rsp;

    // bridge only sees cycles in the upper half
    always_comb begin
        win_req     = bus_req_i;
        win_req.cyc = bus_req_i.cyc && bus_req_i.adr[`TURF_DRP_WINDOW_BIT];
        win_req.stb = bus_req_i.stb && bus_req_i.adr[`TURF_DRP_WINDOW_BIT];
    end

    gt_ctrl_regs u_regs (
        .wb_clk_i  (wb_clk_i),
        .reset_i   (reset_i),
        .bus_req_i (bus_req_i),
        .drp_rsp_i (win_rsp),
        .status_i  (status_i),
        .bus_rsp_o (bus_rsp_o),
        .gt_rst_o  (gt_rst_o)
    );

    drp_bridge u_drp (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .win_req_i  (win_req),
        .win_rsp_o  (win_rsp),
        .drp_en_o   (drp_en_o),
        .drp_we_o   (drp_we_o),
        .drp_addr_o (drp_addr_o),
        .drp_di_o   (drp_di_o),
        .drp_rdy_i  (drp_rdy_i),
        .drp_do_i   (drp_do_i)
    );

    udp_port_classifier u_classify (
        .wb_clk_i      (wb_clk_i),
        .reset_i       (reset_i),
        .hdr_valid_i   (hdr_valid_i),
        .hdr_dest_i    (hdr_dest_i),
        .route_valid_o (route_valid_o),
        .route_o       (route_o)
    );

endmodule

/* logic/turf_defines.svh */
`ifndef TURF_DEFINES_SVH
`define TURF_DEFINES_SVH

// transceiver control bus
`define TURF_ADR_W 14
`define TURF_DAT_W 32

// DRP side of the bridge, one port per lane
`define TURF_DRP_ADR_W 10
`define TURF_DRP_DAT_W 16
`define TURF_NUM_LANES 2

// upper half of the bus space is the DRP window
`define TURF_DRP_WINDOW_BIT 13
// lane select inside the window
`define TURF_LANE_BIT 10

// inbound UDP ports ('Ta', 'Tc', 'Tn', 'Tr', 'Tw')
`define TURF_PORT_TA 16'd21601
`define TURF_PORT_TC 16'd21603
`define TURF_PORT_TN 16'd21614
`define TURF_PORT_TR 16'd21618
`define TURF_PORT_TW 16'd21623

// read/write entry covers 21616 through 21623
`define TURF_MASK_TRW 16'h0007

`endif

/* logic/udp_port_classifier.sv */
`timescale 1ns/1ns
`include "turf_defines.svh"

module udp_port_classifier (
    input  logic                  wb_clk_i,
    input  logic                  reset_i,
    input  logic                  hdr_valid_i,
    input  logic [15:0]           hdr_dest_i,
    output logic                  route_valid_o,
    output udp_route_pkg::route_t route_o
);

    localparam int NUM_IN = 4;

    // inbound table in index order, masked bits are don't-care
    localparam logic [15:0] PORT_TAB [NUM_IN] = '{
        `TURF_PORT_TR, `TURF_PORT_TN, `TURF_PORT_TC, `TURF_PORT_TA
    };
    localparam logic [15:0] MASK_TAB [NUM_IN] = '{
        `TURF_MASK_TRW, 16'h0000, 16'h0000, 16'h0000
    };

    udp_route_pkg::route_t route_d;

    always_comb begin
        route_d.port       = udp_route_pkg::PORT_NONE;
        route_d.reply_port = '0;
        // walk downward so the lowest matching index wins
        for (int i = NUM_IN - 1; i >= 0; i--) begin
            if ((hdr_dest_i & ~MASK_TAB[i]) == (PORT_TAB[i] & ~MASK_TAB[i])) begin
                route_d.port       = udp_route_pkg::in_port_e'(i);
                route_d.reply_port = PORT_TAB[i];
            end
        end
        route_d.is_read = (hdr_dest_i == `TURF_PORT_TR);
        // reads answer from 'Tr', everything else in the range from 'Tw'
        if (route_d.port == udp_route_pkg::PORT_TRW) begin
            route_d.reply_port = route_d.is_read ? `TURF_PORT_TR : `TURF_PORT_TW;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            route_valid_o <= 1'b0;
        end else begin
            route_valid_o <= hdr_valid_i;
        end
    end

    // one result per header, a new one may be taken every cycle
    always_ff @(posedge wb_clk_i) begin
        if (hdr_valid_i) begin
            route_o <= route_d;
        end
    end

    valid_follows_hdr: assert property (
        @(posedge wb_clk_i) disable iff (reset_i)
        route_valid_o |-> $past(hdr_valid_i)
    ) else $error("route strobe without a header the cycle before");

endmodule

/* logic/udp_route_pkg.sv */
package udp_route_pkg;

    // index into the inbound port table
    // the read/write entry is index 0 and covers both 'Tr' and 'Tw'
    typedef enum logic [2:0] {
        PORT_TRW  = 3'd0,
        PORT_TN   = 3'd1,
        PORT_TC   = 3'd2,
        PORT_TA   = 3'd3,
        PORT_NONE = 3'd7
    } in_port_e;

    // routing decision for one inbound header
    typedef struct packed {
        in_port_e    port;
        // request was sent to 'Tr' exactly
        logic        is_read;
        // source port to use for the reply
        logic [15:0] reply_port;
    } route_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_top -f verilog.f

# the verdict comes from the log, not from the exit code of the run
./obj_dir/Vtb_top > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST RESULT: PASS" sim.log; then
    exit 0
fi
exit 1

/* verif/tb_checker.sv */
`timescale 1ns/1ns
`include "turf_defines.svh"

module tb_checker (
    input  logic                       wb_clk_i,
    input  logic                       reset_i,
    input  gt_ctrl_pkg::bus_req_t      bus_req_i,
    input  gt_ctrl_pkg::bus_rsp_t      bus_rsp_i,
    input  logic                       gt_rst_i,
    input  logic [`TURF_NUM_LANES-1:0] drp_en_i,
    input  logic                       drp_we_i,
    input  logic [`TURF_DRP_ADR_W-1:0] drp_addr_i,
    input  logic [`TURF_DRP_DAT_W-1:0] drp_di_i,
    input  logic                       hdr_valid_i,
    input  logic                       route_valid_i,
    input  udp_route_pkg::route_t      route_i,
    output int                         done_o,
    output int                         fail_o
);

    // pending expectations in arrival order
    string                  bus_name_q [$];
    int                     bus_kind_q [$];
    logic [`TURF_ADR_W-1:0] bus_adr_q [$];
    logic [31:0]            bus_exp_q [$];
    string                  route_name_q [$];
    logic [31:0]            route_exp_q [$];

    int                         done_cnt = 0;
    int                         fail_cnt = 0;
    int                         stray_cnt = 0;
    int                         cyc_cnt;
    int                         en_cnt;
    logic                       en_lane;
    logic                       en_we;
    logic [`TURF_DRP_ADR_W-1:0] en_addr;
    logic [`TURF_DRP_DAT_W-1:0] en_di;
    logic                       hdr_seen;
    logic                       rst_exp;

    assign done_o = done_cnt;
    assign fail_o = fail_cnt + stray_cnt;

    task automatic expect_bus(input string name, input int kind,
                              input logic [`TURF_ADR_W-1:0] adr, input logic [31:0] exp);
        bus_name_q.push_back(name);
        bus_kind_q.push_back(kind);
        bus_adr_q.push_back(adr);
        bus_exp_q.push_back(exp);
    endtask

    task automatic expect_route(input string name, input logic [31:0] exp);
        route_name_q.push_back(name);
        route_exp_q.push_back(exp);
    endtask

    task automatic finish_test(input string name, input logic [31:0] exp,
                               input logic [31:0] act, input string problem);
        done_cnt = done_cnt + 1;
        if (problem != "") begin
            fail_cnt = fail_cnt + 1;
            $display("test %s failed: %s", name, problem);
        end else if (act !== exp) begin
            fail_cnt = fail_cnt + 1;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end else begin
            $display("pass %s", name);
        end
    endtask

    task automatic note_stray(input string what);
        stray_cnt = stray_cnt + 1;
        $display("unexpected event: %s", what);
    endtask

    task automatic check_bus_ack();
        string                  name;
        int                     kind;
        logic [`TURF_ADR_W-1:0] adr;
        logic [31:0]            exp;
        logic [31:0]            act;
        string                  problem;
        if (bus_name_q.size() == 0) begin
            note_stray("bus ack with no access pending");
        end else begin
            name = bus_name_q.pop_front();
            kind = bus_kind_q.pop_front();
            adr = bus_adr_q.pop_front();
            exp = bus_exp_q.pop_front();
            problem = "";
            act = bus_rsp_i.dat;
            if (kind < 2) begin
                // reset bit is loaded on the edge that registers the ack
                if (kind == 1) begin
                    act = {31'b0, gt_rst_i};
                    rst_exp = exp[0];
                end
                if (cyc_cnt != 2) begin
                    problem = $sformatf("local ack came %0d cycles after the request",
                                        cyc_cnt - 1);
                end else if (en_cnt != 0) begin
                    problem = "local access started a DRP transaction";
                end
            end else begin
                if (kind == 2) begin
                    act = {16'h0000, en_di};
                end
                if (en_cnt != 1) begin
                    problem = $sformatf("DRP access issued %0d enables instead of one", en_cnt);
                end else if (en_lane != adr[`TURF_LANE_BIT] ||
                             en_addr != adr[`TURF_DRP_ADR_W-1:0]) begin
                    problem = "DRP enable went to the wrong lane or address";
                end else if (en_we != (kind == 2)) begin
                    problem = "DRP write flag does not match the bus access";
                end else if (gt_rst_i !== rst_exp) begin
                    problem = "DRP access changed the transceiver reset";
                end
            end
            finish_test(name, exp, act, problem);
        end
    endtask

    task automatic check_route();
        string       name;
        logic [31:0] exp;
        if (route_valid_i && !hdr_seen) begin
            note_stray("route strobe without a header the cycle before");
        end else if (route_valid_i || hdr_seen) begin
            if (route_name_q.size() == 0) begin
                note_stray("header sent with no result expected");
            end else begin
                name = route_name_q.pop_front();
                exp = route_exp_q.pop_front();
                if (route_valid_i) begin
                    finish_test(name, exp, {12'h000, route_i}, "");
                end else begin
                    finish_test(name, exp, 32'h0, "no route strobe one cycle after the header");
                end
            end
        end
    endtask

    task automatic print_summary();
        $display("tests %0d, passed %0d, failed %0d, other errors %0d",
                 done_cnt, done_cnt - fail_cnt, fail_cnt, stray_cnt);
    endtask

    always @(posedge wb_clk_i) begin
        if (reset_i) begin
            cyc_cnt = 0;
            en_cnt = 0;
            hdr_seen = 1'b0;
            rst_exp = 1'b0;
        end else begin
            // payload is registered together with the enable
            if (drp_en_i != '0) begin
                en_cnt = en_cnt + 1;
                en_lane = drp_en_i[1];
                en_we = drp_we_i;
                en_addr = drp_addr_i;
                en_di = drp_di_i;
            end
            cyc_cnt = bus_req_i.cyc ? cyc_cnt + 1 : 0;
            if (bus_rsp_i.ack) begin
                check_bus_ack();
                cyc_cnt = 0;
                en_cnt = 0;
            end
            check_route();
            hdr_seen = hdr_valid_i;
        end
    end

endmodule

/* verif/tb_top.sv */
`timescale 1ns/1ns
`include "turf_defines.svh"

module tb_top;

    localparam int LANES = `TURF_NUM_LANES;
    localparam int DW    = `TURF_DRP_DAT_W;

    logic                         wb_clk = 1'b0;
    logic                         reset = 1'b1;
    gt_ctrl_pkg::bus_req_t        bus_req = '0;
    gt_ctrl_pkg::bus_rsp_t        bus_rsp;
    gt_ctrl_pkg::gt_status_t      status = '0;
    logic                         gt_rst;
    logic [LANES-1:0]             drp_en;
    logic                         drp_we;
    logic [`TURF_DRP_ADR_W-1:0]   drp_addr;
    logic [DW-1:0]                drp_di;
    logic [LANES-1:0]             drp_rdy = '0;
    logic [LANES*DW-1:0]          drp_do = '0;
    logic                         hdr_valid = 1'b0;
    logic [15:0]                  hdr_dest = '0;
    logic                         route_valid;
    udp_route_pkg::route_t        route;
    int                           done_cnt;
    int                           fail_cnt;

    // tests as read from the data file
    string       names [$];
    int          kinds [$];
    logic [31:0] args [$];
    logic [31:0] wdatas [$];
    logic [31:0] exps [$];
    int          n_tests = 0;
    bit          loaded = 1'b0;

    // DRP lane model state
    logic [DW-1:0]              lane_mem [LANES][1024];
    logic [LANES-1:0]           lane_busy = '0;
    logic [2:0]                 lane_wait [LANES];
    logic                       lane_we [LANES];
    logic [`TURF_DRP_ADR_W-1:0] lane_addr [LANES];
    logic [DW-1:0]              lane_di [LANES];
    logic [15:0]                lfsr_q = 16'd10307;

    turf_ctrl_top dut (
        .wb_clk_i      (wb_clk),
        .reset_i       (reset),
        .bus_req_i     (bus_req),
        .bus_rsp_o     (bus_rsp),
        .status_i      (status),
        .gt_rst_o      (gt_rst),
        .drp_en_o      (drp_en),
        .drp_we_o      (drp_we),
        .drp_addr_o    (drp_addr),
        .drp_di_o      (drp_di),
        .drp_rdy_i     (drp_rdy),
        .drp_do_i      (drp_do),
        .hdr_valid_i   (hdr_valid),
        .hdr_dest_i    (hdr_dest),
        .route_valid_o (route_valid),
        .route_o       (route)
    );

    tb_checker chk (
        .wb_clk_i      (wb_clk),
        .reset_i       (reset),
        .bus_req_i     (bus_req),
        .bus_rsp_i     (bus_rsp),
        .gt_rst_i      (gt_rst),
        .drp_en_i      (drp_en),
        .drp_we_i      (drp_we),
        .drp_addr_i    (drp_addr),
        .drp_di_i      (drp_di),
        .hdr_valid_i   (hdr_valid),
        .route_valid_i (route_valid),
        .route_i       (route),
        .done_o        (done_cnt),
        .fail_o        (fail_cnt)
    );

    initial begin
        forever #10 wb_clk = ~wb_clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // each lane answers its enable after 1 to 4 cycles
    always @(posedge wb_clk) begin
        logic [15:0] rnd;
        logic [1:0]  pick;
        rnd = lfsr_q;
        for (int l = 0; l < LANES; l++) begin
            drp_rdy[l] <= 1'b0;
            if (reset) begin
                lane_busy[l] <= 1'b0;
                for (int a = 0; a < 1024; a++) begin
                    lane_mem[l][a] <= 16'h3c00 ^ 16'(a) ^ 16'(l << 12);
                end
            end else if (lane_busy[l]) begin
                if (lane_wait[l] == 3'd1) begin
                    lane_busy[l] <= 1'b0;
                    drp_rdy[l] <= 1'b1;
                    if (lane_we[l]) begin
                        lane_mem[l][lane_addr[l]] <= lane_di[l];
                    end else begin
                        drp_do[l*DW +: DW] <= lane_mem[l][lane_addr[l]];
                    end
                end else begin
                    lane_wait[l] <= lane_wait[l] - 3'd1;
                end
            end else if (drp_en[l]) begin
                rnd = lfsr_next(rnd);
                pick[0] = rnd[0];
                rnd = lfsr_next(rnd);
                pick[1] = rnd[0];
                lane_busy[l] <= 1'b1;
                lane_wait[l] <= {1'b0, pick} + 3'd1;
                lane_we[l] <= drp_we;
                lane_addr[l] <= drp_addr;
                lane_di[l] <= drp_di;
            end
        end
        lfsr_q <= rnd;
    end

    task automatic load_tests(output bit ok);
        int          fd;
        string       line;
        string       name;
        int          kind;
        logic [31:0] arg;
        logic [31:0] wdata;
        logic [31:0] expv;
        ok = 1'b0;
        fd = $fopen("verif/test_input.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%s %h %h %h %h", name, kind, arg, wdata, expv) == 5
                        && kind >= 0 && kind <= 5) begin
                        names.push_back(name);
                        kinds.push_back(kind);
                        args.push_back(arg);
                        wdatas.push_back(wdata);
                        exps.push_back(expv);
                    end else begin
                        $display("bad line in the test file: %s", line);
                        ok = 1'b0;
                    end
                end
            end
            $fclose(fd);
        end
        n_tests = names.size();
    endtask

    task automatic bus_access(input logic [`TURF_ADR_W-1:0] adr, input logic we,
                              input logic [3:0] sel, input logic [31:0] dat);
        gt_ctrl_pkg::bus_req_t req;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we = we;
        req.sel = sel;
        req.adr = adr;
        req.dat = dat;
        @(posedge wb_clk);
        bus_req <= req;
        // hold the cycle until the target acks
        do begin
            @(posedge wb_clk);
        end while (!bus_rsp.ack);
        bus_req <= '0;
    endtask

    task automatic run_test(input int i);
        case (kinds[i])
            0: begin
                chk.expect_bus(names[i], 0, '0, exps[i]);
                @(posedge wb_clk);
                status <= gt_ctrl_pkg::gt_status_t'(args[i][3:0]);
                bus_access('0, 1'b0, 4'hf, '0);
            end
            1: begin
                chk.expect_bus(names[i], 1, '0, exps[i]);
                bus_access('0, 1'b1, args[i][3:0], wdatas[i]);
            end
            2, 3: begin
                chk.expect_bus(names[i], kinds[i], args[i][`TURF_ADR_W-1:0], exps[i]);
                bus_access(args[i][`TURF_ADR_W-1:0], kinds[i] == 2, 4'hf, wdatas[i]);
            end
            default: begin
                chk.expect_route(names[i], exps[i]);
                @(posedge wb_clk);
                hdr_valid <= 1'b1;
                hdr_dest <= args[i][15:0];
                // a chained header right behind keeps the strobe up
                if (i + 1 >= n_tests || kinds[i + 1] != 5) begin
                    @(posedge wb_clk);
                    hdr_valid <= 1'b0;
                end
            end
        endcase
    endtask

    initial begin
        bit ok;
        load_tests(ok);
        if (!ok || n_tests == 0) begin
            $display("could not read the tests from verif/test_input.txt");
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (10) @(posedge wb_clk);
            reset <= 1'b0;
            for (int i = 0; i < n_tests; i++) begin
                run_test(i);
            end
            wait (done_cnt == n_tests);
            repeat (2) @(posedge wb_clk);
            chk.print_summary();
            if (fail_cnt == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

    // watchdog, 50 cycles per test
    initial begin
        wait (loaded);
        repeat (n_tests * 50) @(posedge wb_clk);
        $display("run timed out after %0d cycles with tests still open", n_tests * 50);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

/* verif/test_input.txt */
# columns: name kind arg wdata expected, numbers in hex
# kind 0 status read (arg = status_i), 1 reset write (arg = sel, expected = gt_rst_o after it)
# kind 2 DRP write (arg = bus address, expected = DRP data out), 3 DRP read (expected = read data)
# kind 4 header (arg = destination port, expected = route_t), 5 header on the cycle after the last
stat_a 0 a 0 a
stat_5 0 5 0 5
stat_0 0 0 0 0
rst_set 1 1 1 1
rst_nosel_clear 1 e 0 1
rst_clear 1 1 fffffffe 0
rst_nosel_set 1 0 1 0
drp_w_l0 2 2055 1234 1234
drp_w_l1 2 2455 beef beef
drp_r_l0 3 2055 0 1234
drp_r_l1 3 2455 0 beef
drp_w_l1_top 2 27ff a5c3 a5c3
drp_r_l1_top 3 27ff 0 a5c3
hdr_ta_21601 4 5461 0 65461
hdr_tc_21603 4 5463 0 45463
hdr_tn_21614 4 546e 0 2546e
hdr_tr_21618 4 5472 0 15472
hdr_rw_21616 4 5470 0 5477
hdr_rw_21620 4 5474 0 5477
hdr_tw_21623 4 5477 0 5477
hdr_none_21624 4 5478 0 e0000
hdr_none_21552 4 5430 0 e0000
b2b_ta 4 5461 0 65461
b2b_tr 5 5472 0 15472
b2b_none 5 5478 0 e0000
b2b_tw 5 5477 0 5477

/* verilog.f */
+incdir+logic
logic/gt_ctrl_pkg.sv
logic/udp_route_pkg.sv
logic/gt_ctrl_regs.sv
logic/drp_bridge.sv
logic/udp_port_classifier.sv
logic/turf_ctrl_top.sv
verif/tb_checker.sv
verif/tb_top.sv
